// ==== src/pad_dma_defs.svh ====
/*
 * Shared constants of the padding DMA engine.
 * Include wherever widths, tile geometry or register offsets are needed.
 */
`ifndef PAD_DMA_DEFS_SVH
`define PAD_DMA_DEFS_SVH

// Bus widths
`define PD_DATA_W       32
`define PD_ADDR_W       32
`define PD_COORD_W      6       // Matrix width and tile index

// Tile geometry
`define PD_TILE         4       // Source tile side
`define PD_BUF          6       // Tile plus one border word per side
`define PD_BEAT_BYTES   4

// Register byte offsets
`define PD_REG_SRC      4'h0
`define PD_REG_DST      4'h4
`define PD_REG_WIDTH    4'h8
`define PD_REG_CTRL     4'hC

`endif

// ==== src/pad_dma_pkg.sv ====
/*
 * Types shared by the register block, the sequencer and the tile buffer.
 * Import with a wildcard in the module header.
 */
`default_nettype none

`include "pad_dma_defs.svh"

package pad_dma_pkg;

    typedef logic [`PD_DATA_W-1:0]  word_t;
    typedef logic [`PD_ADDR_W-1:0]  addr_t;
    typedef logic [`PD_COORD_W-1:0] coord_t;

    // Row or column inside the 6x6 tile buffer
    typedef logic [$clog2(`PD_BUF)-1:0] buf_idx_t;

    // Set when the tile touches that border of the matrix
    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_t;

    typedef enum logic [2:0] {
        IDLE,
        RREQ,       // AR for one source row
        RDATA,
        PAD,        // Reflect fill of the tile buffer
        WREQ,       // AW for one output row
        WDATA,
        WRESP
    } seq_state_e;

endpackage

`default_nettype wire

// ==== src/dma_cfg_if.sv ====
/*
 * Run configuration and start/done handshake between the register block
 * and the tile sequencer.
 */
`timescale 1ns/1ps
`default_nettype none

interface dma_cfg_if import pad_dma_pkg::*; ();

    addr_t  src_addr;
    addr_t  dst_addr;
    coord_t width;
    logic   start;      // One cycle, only while done is high
    logic   done;

    modport regs (output src_addr, dst_addr, width, start, input done);
    modport seq  (input src_addr, dst_addr, width, start, output done);

endinterface

`default_nettype wire

// ==== src/tile_buf_if.sv ====
/*
 * Store, pad and read port of the tile buffer as seen by the sequencer.
 * Read data is combinational from rd_x/rd_y.
 */
`timescale 1ns/1ps
`default_nettype none

interface tile_buf_if import pad_dma_pkg::*; ();

    logic     st_en;
    buf_idx_t st_x;         // Column
    buf_idx_t st_y;         // Row
    word_t    st_data;
    logic     pad_en;
    edge_t    edges;
    buf_idx_t rd_x;
    buf_idx_t rd_y;
    word_t    rd_data;

    modport seq (
        output st_en, st_x, st_y, st_data, pad_en, edges, rd_x, rd_y,
        input  rd_data
    );
    modport buffer (
        input  st_en, st_x, st_y, st_data, pad_en, edges, rd_x, rd_y,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== src/pad_dma_regs.sv ====
/*
 * Wishbone classic slave holding source, destination and width.
 * A CTRL write with bit 0 set starts a run; CTRL bit 0 reads back done.
 */
`timescale 1ns/1ps
`default_nettype none

`include "pad_dma_defs.svh"

module pad_dma_regs import pad_dma_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,

    input  logic    wb_cyc_i,
    input  logic    wb_stb_i,
    input  logic    wb_we_i,
    input  addr_t   wb_adr_i,
    input  word_t   wb_dat_i,
    output word_t   wb_dat_o,
    output logic    wb_ack_o,

    dma_cfg_if.regs cfg
);

    addr_t      src_q;
    addr_t      dst_q;
    coord_t     width_q;
    logic       ack_q;
    logic       start_q;
    word_t      rdata_q;
    logic       req;
    logic       width_ok;
    logic [3:0] offset;

    assign req      = wb_cyc_i && wb_stb_i && !ack_q;  // New access, not yet acked
    assign offset   = wb_adr_i[3:0];
    assign width_ok = (width_q != '0) && (width_q[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
            src_q   <= '0;
            dst_q   <= '0;
            width_q <= '0;
        end else begin
            ack_q   <= req;
            // Start rides with the ack of the CTRL write
            start_q <= req && wb_we_i && (offset == `PD_REG_CTRL) && wb_dat_i[0]
                       && cfg.done && width_ok;
            if (req && wb_we_i) begin
                case (offset)
                    `PD_REG_SRC:   src_q   <= wb_dat_i;
                    `PD_REG_DST:   dst_q   <= wb_dat_i;
                    `PD_REG_WIDTH: width_q <= wb_dat_i[`PD_COORD_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data, valid with ack
    always_ff @(posedge clk) begin
        if (req) begin
            case (offset)
                `PD_REG_SRC:   rdata_q <= src_q;
                `PD_REG_DST:   rdata_q <= dst_q;
                `PD_REG_WIDTH: rdata_q <= word_t'(width_q);
                `PD_REG_CTRL:  rdata_q <= word_t'(cfg.done);
                default:       rdata_q <= '0;
            endcase
        end
    end

    assign wb_dat_o     = rdata_q;
    assign wb_ack_o     = ack_q;
    assign cfg.src_addr = src_q;
    assign cfg.dst_addr = dst_q;
    assign cfg.width    = width_q;
    assign cfg.start    = start_q;

endmodule

`default_nettype wire

// ==== src/tile_sequencer.sv ====
/*
 * Walks the matrix in 4x4 tiles, reads each tile row by row over AXI,
 * has the tile buffer add the reflected border, then writes one burst per output row.
 */
`timescale 1ns/1ps
`default_nettype none

`include "pad_dma_defs.svh"

module tile_sequencer import pad_dma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    dma_cfg_if.seq      cfg,
    tile_buf_if.seq     tb,

    output addr_t       araddr_o,
    output logic [3:0]  arlen_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  word_t       rdata_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    output addr_t       awaddr_o,
    output logic [3:0]  awlen_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output word_t       wdata_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  logic        bvalid_i,
    output logic        bready_o
);

    seq_state_e state;
    logic       done_q;
    addr_t      src_q;
    addr_t      dst_q;
    coord_t     width_q;
    coord_t     bx;             // Tile column
    coord_t     by;             // Tile row
    logic [1:0] rrow;
    logic [1:0] rcol;
    buf_idx_t   wrow;
    buf_idx_t   wcnt;           // Beat within the write burst

    coord_t     last_tile;
    edge_t      edges;
    buf_idx_t   nrows;
    buf_idx_t   rlen;
    addr_t      rd_row, rd_col;
    addr_t      wr_row, wr_col;
    logic       ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign last_tile = width_q / `PD_TILE - 1'b1;
    assign edges.top    = (by == '0);
    assign edges.bottom = (by == last_tile);
    assign edges.left   = (bx == '0);
    assign edges.right  = (bx == last_tile);

    // One extra row or column for each border the tile touches
    assign nrows = buf_idx_t'(`PD_TILE) + buf_idx_t'(edges.top) + buf_idx_t'(edges.bottom);
    assign rlen  = buf_idx_t'(`PD_TILE) + buf_idx_t'(edges.left) + buf_idx_t'(edges.right);

    assign ar_hs = arvalid_o && arready_i;
    assign r_hs  = rvalid_i && rready_o;
    assign aw_hs = awvalid_o && awready_i;
    assign w_hs  = wvalid_o && wready_i;
    assign b_hs  = bvalid_i && bready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            done_q <= 1'b1;
            bx     <= '0;
            by     <= '0;
            rrow   <= '0;
            rcol   <= '0;
            wrow   <= '0;
            wcnt   <= '0;
        end else begin
            case (state)
                IDLE: if (cfg.start) begin
                    done_q <= 1'b0;
                    bx     <= '0;
                    by     <= '0;
                    rrow   <= '0;
                    rcol   <= '0;
                    state  <= RREQ;
                end
                RREQ: if (ar_hs) state <= RDATA;
                RDATA: if (r_hs) begin
                    rcol <= rcol + 1'b1;
                    if (rlast_i) begin
                        rcol <= '0;
                        if (rrow == 2'(`PD_TILE - 1)) begin
                            state <= PAD;
                        end else begin
                            rrow  <= rrow + 1'b1;
                            state <= RREQ;
                        end
                    end
                end
                PAD: begin
                    wrow  <= '0;
                    state <= WREQ;
                end
                WREQ: if (aw_hs) begin
                    wcnt  <= '0;
                    state <= WDATA;
                end
                WDATA: if (w_hs) begin
                    wcnt <= wcnt + 1'b1;
                    if (wlast_o) state <= WRESP;    // Overridden below if B came along
                end
                default: ;
            endcase

            // Row finished once its B is accepted
            if (b_hs) begin
                if (wrow != nrows - 1'b1) begin
                    wrow  <= wrow + 1'b1;
                    state <= WREQ;
                end else if (bx == last_tile && by == last_tile) begin
                    done_q <= 1'b1;
                    state  <= IDLE;
                end else begin
                    rrow  <= '0;
                    state <= RREQ;
                    if (bx == last_tile) begin
                        bx <= '0;
                        by <= by + 1'b1;
                    end else begin
                        bx <= bx + 1'b1;
                    end
                end
            end
        end
    end

    // Run configuration, taken at start
    always_ff @(posedge clk) begin
        if (state == IDLE && cfg.start) begin
            src_q   <= cfg.src_addr;
            dst_q   <= cfg.dst_addr;
            width_q <= cfg.width;
        end
    end

    // Source (row, col) of the first beat of the read burst
    assign rd_row = addr_t'(by) * `PD_TILE + addr_t'(rrow);
    assign rd_col = addr_t'(bx) * `PD_TILE;
    // Padded (row, col) of the first beat of the write burst
    assign wr_row = addr_t'(by) * `PD_TILE + addr_t'(wrow) + addr_t'(!edges.top);
    assign wr_col = addr_t'(bx) * `PD_TILE + addr_t'(!edges.left);

    assign araddr_o  = src_q + (rd_row * addr_t'(width_q) + rd_col) * `PD_BEAT_BYTES;
    assign arlen_o   = 4'(`PD_TILE - 1);
    assign arvalid_o = (state == RREQ);
    assign rready_o  = (state == RDATA);

    assign awaddr_o  = dst_q + (wr_row * (addr_t'(width_q) + 2) + wr_col) * `PD_BEAT_BYTES;
    assign awlen_o   = 4'(rlen) - 4'd1;
    assign awvalid_o = (state == WREQ);
    assign wvalid_o  = (state == WDATA);
    assign wlast_o   = wvalid_o && (wcnt == rlen - 1'b1);
    assign wdata_o   = tb.rd_data;
    assign bready_o  = (state == WRESP) || (wlast_o && wready_i);

    // Source words always land at offset (1, 1), leaving row/col 0 for the border
    assign tb.st_en   = r_hs;
    assign tb.st_x    = buf_idx_t'(rcol) + 1'b1;
    assign tb.st_y    = buf_idx_t'(rrow) + 1'b1;
    assign tb.st_data = rdata_i;
    assign tb.pad_en  = (state == PAD);
    assign tb.edges   = edges;
    assign tb.rd_x    = (edges.left ? buf_idx_t'(0) : buf_idx_t'(1)) + wcnt;
    assign tb.rd_y    = (edges.top ? buf_idx_t'(0) : buf_idx_t'(1)) + wrow;

    assign cfg.done = done_q;

endmodule

`default_nettype wire

// ==== src/tile_buffer.sv ====
/*
 * 6x6 word buffer for one 4x4 source tile and its border.
 * Stores land at the next edge; the reflect fill is done in the pad cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "pad_dma_defs.svh"

module tile_buffer import pad_dma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    tile_buf_if.buffer  tb
);

    localparam int N = `PD_BUF;

    word_t mem [N][N];      // mem[row][col], tile sits at rows/cols 1..4

    // Buffer index a border word copies from, or itself when no fill applies.
    // Low border reflects index 2, high border reflects index N-3.
    function automatic int fill_src(input int idx, input logic lo, input logic hi);
        if (lo && idx == 0) begin
            return 2;
        end
        if (hi && idx == N - 1) begin
            return N - 3;
        end
        return idx;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    mem[i][j] <= '0;
                end
            end
        end else if (tb.pad_en) begin
            // Corners pick up the diagonal neighbor when both flags are set
            for (int i = 0; i < N; i++) begin
                for (int j = 0; j < N; j++) begin
                    mem[i][j] <= mem[fill_src(i, tb.edges.top, tb.edges.bottom)]
                                    [fill_src(j, tb.edges.left, tb.edges.right)];
                end
            end
        end else if (tb.st_en) begin
            mem[tb.st_y][tb.st_x] <= tb.st_data;
        end
    end

    assign tb.rd_data = mem[tb.rd_y][tb.rd_x];     // Feeds W data directly

endmodule

`default_nettype wire

// ==== src/pad_dma_top.sv ====
/*
 * Padding DMA top level. Wishbone classic slave for configuration,
 * AXI master for the source reads and padded writes.
 */
`timescale 1ns/1ps
`default_nettype none

module pad_dma_top import pad_dma_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    // Wishbone classic slave
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  addr_t       wb_adr_i,
    input  word_t       wb_dat_i,
    output word_t       wb_dat_o,
    output logic        wb_ack_o,

    // AXI read
    output addr_t       araddr_o,
    output logic [3:0]  arlen_o,
    output logic        arvalid_o,
    input  logic        arready_i,
    input  word_t       rdata_i,
    input  logic        rlast_i,
    input  logic        rvalid_i,
    output logic        rready_o,

    // AXI write
    output addr_t       awaddr_o,
    output logic [3:0]  awlen_o,
    output logic        awvalid_o,
    input  logic        awready_i,
    output word_t       wdata_o,
    output logic        wlast_o,
    output logic        wvalid_o,
    input  logic        wready_i,
    input  logic        bvalid_i,
    output logic        bready_o,

    output logic        done_o
);

    dma_cfg_if  cfg_if ();
    tile_buf_if tb_if ();

    pad_dma_regs i_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .cfg      (cfg_if.regs)
    );

    tile_sequencer i_seq (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg_if.seq),
        .tb        (tb_if.seq),
        .araddr_o  (araddr_o),
        .arlen_o   (arlen_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rlast_i   (rlast_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o),
        .awaddr_o  (awaddr_o),
        .awlen_o   (awlen_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wlast_o   (wlast_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o)
    );

    tile_buffer i_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .tb    (tb_if.buffer)
    );

    assign done_o = cfg_if.done;

endmodule

`default_nettype wire

// ==== dv/pad_dma_props.sv ====
/*
 * Handshake properties of the padding DMA, bound to the top level.
 */
`timescale 1ns/1ps
`default_nettype none

module pad_dma_props import pad_dma_pkg::*; (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        wb_stb_i,
    input wire logic        wb_ack_o,
    input wire addr_t       araddr_o,
    input wire logic [3:0]  arlen_o,
    input wire logic        arvalid_o,
    input wire logic        arready_i,
    input wire addr_t       awaddr_o,
    input wire logic [3:0]  awlen_o,
    input wire logic        awvalid_o,
    input wire logic        awready_i,
    input wire word_t       wdata_o,
    input wire logic        wlast_o,
    input wire logic        wvalid_o,
    input wire logic        wready_i,
    input wire logic        done_o
);

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
        else $error("AR dropped or changed before ready");

    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awlen_o))
        else $error("AW dropped or changed before ready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wlast_o))
        else $error("W dropped or changed before ready");

    ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack_o |-> wb_stb_i)
        else $error("Wishbone ack without strobe");

    // No bus traffic while idle
    idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> !(arvalid_o || awvalid_o || wvalid_o))
        else $error("AXI valid raised while done is high");

endmodule

bind pad_dma_top pad_dma_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_stb_i  (wb_stb_i),
    .wb_ack_o  (wb_ack_o),
    .araddr_o  (araddr_o),
    .arlen_o   (arlen_o),
    .arvalid_o (arvalid_o),
    .arready_i (arready_i),
    .awaddr_o  (awaddr_o),
    .awlen_o   (awlen_o),
    .awvalid_o (awvalid_o),
    .awready_i (awready_i),
    .wdata_o   (wdata_o),
    .wlast_o   (wlast_o),
    .wvalid_o  (wvalid_o),
    .wready_i  (wready_i),
    .done_o    (done_o)
);

`default_nettype wire

// ==== dv/pad_dma_tb.sv ====
/*
 * Testbench for the padding DMA. Runs the lines of dv/pad_dma_trace.txt over
 * Wishbone and checks the padded matrix written to the AXI memory model.
 */
`timescale 1ns/1ps
`default_nettype none

`include "pad_dma_defs.svh"

module pad_dma_tb import pad_dma_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst_n = 1'b0;
    logic       wb_cyc_i = 1'b0, wb_stb_i = 1'b0, wb_we_i = 1'b0;
    addr_t      wb_adr_i = '0;
    word_t      wb_dat_i = '0;
    word_t      wb_dat_o, wdata_o;
    logic       wb_ack_o, done_o;
    addr_t      araddr_o, awaddr_o;
    logic [3:0] arlen_o, awlen_o;
    logic       arvalid_o, rready_o, awvalid_o, wlast_o, wvalid_o, bready_o;
    logic       arready_i = 1'b0, rlast_i = 1'b0, rvalid_i = 1'b0;
    logic       awready_i = 1'b0, wready_i = 1'b0, bvalid_i = 1'b0;
    word_t      rdata_i = '0;

    integer     seed = 18;
    logic       stall_en = 1'b0;
    word_t      mem [addr_t];       // Unwritten words hold their own byte address
    int         err_cnt = 0;        // Wrong values
    int         fail_cnt = 0;       // Timeouts and other failures
    addr_t      r_addr, w_addr;
    int         r_left = 0, w_left = 0;
    logic       b_due = 1'b0;

    pad_dma_top i_pad_dma_top (.*);

    always #5 clk = ~clk;

    function automatic logic stall_ready();
        return stall_en ? logic'($random(seed)) : 1'b1;
    endfunction

    function automatic word_t mem_read(input addr_t a);
        return mem.exists(a) ? mem[a] : word_t'(a);
    endfunction

    // Reflect rule for one padded coordinate
    function automatic int reflect(input int k, input int w);
        if (k < 0) return 1;
        if (k >= w) return w - 2;
        return k;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // AXI read slave
    always @(posedge clk) begin
        if (!rst_n) begin
            arready_i <= 1'b0;
            rvalid_i  <= 1'b0;
            rlast_i   <= 1'b0;
            r_left = 0;
        end else begin
            arready_i <= stall_ready();
            if (rvalid_i && rready_o) begin
                r_addr = r_addr + `PD_BEAT_BYTES;
                r_left = r_left - 1;
            end
            if (arvalid_o && arready_i) begin
                r_addr = araddr_o;
                r_left = int'(arlen_o) + 1;
            end
            if (!(rvalid_i && !rready_o)) begin     // A beat not yet taken stays put
                if (r_left > 0 && stall_ready()) begin
                    rvalid_i <= 1'b1;
                    rdata_i  <= mem_read(r_addr);
                    rlast_i  <= (r_left == 1);
                end else begin
                    rvalid_i <= 1'b0;
                    rlast_i  <= 1'b0;
                end
            end
        end
    end

    // AXI write slave, B after the last beat
    always @(posedge clk) begin
        if (!rst_n) begin
            awready_i <= 1'b0;
            wready_i  <= 1'b0;
            bvalid_i  <= 1'b0;
            b_due = 1'b0;
        end else begin
            awready_i <= stall_ready();
            wready_i  <= stall_ready();
            if (awvalid_o && awready_i) begin
                w_addr = awaddr_o;
                w_left = int'(awlen_o) + 1;
            end
            if (wvalid_o && wready_i) begin
                check_bit("wlast_o", wlast_o, w_left == 1);
                mem[w_addr] = wdata_o;
                w_addr = w_addr + `PD_BEAT_BYTES;
                w_left = w_left - 1;
                if (wlast_o) b_due = 1'b1;
            end
            if (bvalid_i) begin
                if (bready_o) bvalid_i <= 1'b0;
            end else if (b_due && stall_ready()) begin
                bvalid_i <= 1'b1;
                b_due = 1'b0;
            end
        end
    end

    task automatic wb_access(input logic we, input addr_t adr, input word_t dat_w,
                             output word_t dat_r);
        int   t;
        logic got;
        @(posedge clk);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= dat_w;
        got = 1'b0;
        t = 0;
        while (!got && t < 16) begin
            @(posedge clk);
            got = (wb_ack_o === 1'b1);
            t++;
        end
        dat_r = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        if (!got) begin
            $display("Wishbone access to address %h got no ack", adr);
            fail_cnt++;
        end
    endtask

    task automatic wb_write(input addr_t adr, input word_t dat);
        word_t unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wait_done(input logic level, input int limit);
        int t;
        t = 0;
        while (done_o !== level && t < limit) begin
            @(posedge clk);
            t++;
        end
        if (done_o !== level) begin
            $display("Timed out waiting for done to become %b", level);
            fail_cnt++;
        end
    endtask

    // Every padded word present and correct, nothing written elsewhere
    task automatic check_padded(input addr_t src, input addr_t dst, input int w);
        addr_t a;
        addr_t last;
        last = dst + addr_t'((w + 2) * (w + 2) * `PD_BEAT_BYTES);
        for (int r = 0; r < w + 2; r++) begin
            for (int c = 0; c < w + 2; c++) begin
                a = dst + addr_t'((r * (w + 2) + c) * `PD_BEAT_BYTES);
                if (!mem.exists(a)) begin
                    $display("Padded word (%0d, %0d) at %h was never written", r, c, a);
                    fail_cnt++;
                end else begin
                    check_word($sformatf("wdata_o[%0d][%0d]", r, c), mem[a],
                        src + addr_t'((reflect(r - 1, w) * w + reflect(c - 1, w)) * 4));
                end
            end
        end
        foreach (mem[k]) begin
            if (k < dst || k >= last) begin
                $display("Word at %h written outside the destination buffer", k);
                fail_cnt++;
            end
        end
    endtask

    task automatic run_matrix(input addr_t src, input addr_t dst, input int w,
                              input logic second_start);
        mem.delete();
        wb_write(`PD_REG_SRC, src);
        wb_write(`PD_REG_DST, dst);
        wb_write(`PD_REG_WIDTH, w);
        wb_write(`PD_REG_CTRL, 1);
        wait_done(1'b0, 20);
        if (second_start) begin
            wb_write(`PD_REG_SRC, src + 32'h100);   // Must not reach the running job
            wb_write(`PD_REG_CTRL, 1);
        end
        wait_done(1'b1, 100000);
        check_padded(src, dst, w);
    endtask

    task automatic readback(input addr_t src, input addr_t dst, input int w);
        word_t d;
        wb_access(1'b0, `PD_REG_CTRL, '0, d);
        check_word("wb_dat_o", d, 32'h1);
        wb_write(`PD_REG_SRC, src);
        wb_write(`PD_REG_DST, dst);
        wb_write(`PD_REG_WIDTH, w);
        wb_access(1'b0, `PD_REG_SRC, '0, d);
        check_word("wb_dat_o", d, src);
        wb_access(1'b0, `PD_REG_DST, '0, d);
        check_word("wb_dat_o", d, dst);
        wb_access(1'b0, `PD_REG_WIDTH, '0, d);
        check_word("wb_dat_o", d, word_t'(w));
    endtask

    task automatic illegal_start(input int w);
        wb_write(`PD_REG_WIDTH, w);
        wb_write(`PD_REG_CTRL, 1);
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check_bit("done_o", done_o, 1'b1);
            check_bit("arvalid_o", arvalid_o, 1'b0);
            check_bit("awvalid_o", awvalid_o, 1'b0);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    mode, width, stall;
        addr_t src, dst;
        string line;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        fd = $fopen("dv/pad_dma_trace.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the trace file dv/pad_dma_trace.txt");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", mode, src, dst, width, stall);
                    if (n == 5) begin
                        stall_en = (stall != 0);
                        case (mode)
                            0: readback(src, dst, width);
                            1: run_matrix(src, dst, width, 1'b0);
                            2: illegal_start(width);
                            3: run_matrix(src, dst, width, 1'b1);
                            default: begin
                                $display("Unknown mode %0d in trace", mode);
                                fail_cnt++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
        $display("Summary: %0d value errors, %0d other failures", err_cnt, fail_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pad_dma.f ====
+incdir+src
src/pad_dma_pkg.sv
src/dma_cfg_if.sv
src/tile_buf_if.sv
src/pad_dma_regs.sv
src/tile_sequencer.sv
src/tile_buffer.sv
src/pad_dma_top.sv
dv/pad_dma_props.sv
dv/pad_dma_tb.sv

// ==== dv/pad_dma_trace.txt ====
# mode src dst width stall, all hex
# mode 0 register readback, 1 run, 2 illegal width start, 3 run with a second start
0 00001000 00002000 0c 0
1 00001000 00008000 04 0
1 00001000 00008000 08 0
1 00001000 00008000 0c 0
1 00001000 00008000 0c 1
2 00001000 00008000 00 0
2 00001000 00008000 06 0
3 00003000 00010000 08 1
